//--- verilog/cp0_defs.svh
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// coprocessor 0 register numbers
`define CP0_BADVADDR 5'd8
`define CP0_COUNT 5'd9
`define CP0_COMPARE 5'd11
`define CP0_STATUS 5'd12
`define CP0_CAUSE 5'd13
`define CP0_EPC 5'd14

// interrupts globally enabled out of reset
`define CP0_STATUS_RESET_IE 1'b1

// BEV is hardwired, only ever seen on reads
`define CP0_STATUS_BEV 32'h0040_0000

// branch sits one word before its delay slot
`define CP0_DSLOT_OFFSET 32'd4

`endif

//--- verilog/cp0_word_pkg.sv
package cp0_word_pkg;

    // data or address word on the mtc0/mfc0 path
    typedef logic [31:0] cp0_word;

    // coprocessor register number, rd field of mtc0/mfc0
    typedef logic [4:0] cp0_idx;

    // external interrupt pins, level sensitive
    typedef logic [5:0] ext_int_vec;

endpackage

//--- verilog/cp0_exc_pkg.sv
package cp0_exc_pkg;

    // Cause.ExcCode, pipeline hands over 6 bits and only 5 are kept
    typedef logic [4:0] exc_code;

    // IM / IP layout
    // bit 7 timer, bits 6..2 external, bits 1..0 software
    typedef logic [7:0] int_mask;

    // Cause.IP[1:0], written by mtc0 only
    typedef logic [1:0] sw_int;

endpackage

//--- verilog/cp0_timer.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0_timer (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  cp0_write,
    input  logic                  eret,
    input  logic                  exception,
    input  cp0_word_pkg::cp0_idx  cp0_idx,
    input  cp0_word_pkg::cp0_word cp0_wdata,
    output cp0_word_pkg::cp0_word count,
    output cp0_word_pkg::cp0_word compare,
    output logic                  timer_pending
);

    logic tick;
    logic compare_set;
    logic wr_ok;
    logic wr_count;
    logic wr_compare;
    logic match;

    // eret and exception win over mtc0
    assign wr_ok = cp0_write & ~eret & ~exception;
    assign wr_count = wr_ok && (cp0_idx == `CP0_COUNT);
    assign wr_compare = wr_ok && (cp0_idx == `CP0_COMPARE);

    assign match = compare_set && (count == compare);

    // count moves on every other edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (wr_count) begin
            count <= cp0_wdata;
        end else begin
            count <= count + {31'd0, tick};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            compare <= '0;
            compare_set <= 1'b0;
        end else if (wr_compare) begin
            compare <= cp0_wdata;
            compare_set <= 1'b1;
        end
    end

    // sticky until the next Compare write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_pending <= 1'b0;
        end else if (wr_compare) begin
            timer_pending <= (count == cp0_wdata);
        end else begin
            timer_pending <= timer_pending | match;
        end
    end

    // a rise needs a written Compare equal to the Count of the edge before
    a_pending_needs_compare: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(timer_pending) |-> compare_set && (compare == $past(count))
    ) else $error("timer interrupt raised without a matching Compare write");

endmodule

//--- verilog/cp0_irq.sv
`timescale 1ns/1ps

module cp0_irq (
    input  cp0_word_pkg::ext_int_vec ext_int,
    input  logic                     timer_pending,
    input  cp0_exc_pkg::sw_int       cause_sw,
    input  cp0_exc_pkg::int_mask     status_im,
    input  logic                     status_ie,
    input  logic                     status_exl,
    output cp0_exc_pkg::int_mask     int_pending,
    output logic                     interrupt
);

    cp0_exc_pkg::int_mask raw_src;
    cp0_exc_pkg::int_mask timer_src;
    cp0_exc_pkg::int_mask hw_src;
    cp0_exc_pkg::int_mask soft_src;
    logic                 int_enable;

    // timer shares IP7 with the top external pin, as on classic MIPS
    assign timer_src = {timer_pending, 7'b000_0000};
    assign hw_src = {ext_int, 2'b00};
    assign soft_src = {6'b00_0000, cause_sw};

    assign raw_src = timer_src | hw_src | soft_src;

    // only what IM lets through is reported as pending
    assign int_pending = raw_src & status_im;

    // nothing is taken while a handler is still running
    assign int_enable = status_ie & ~status_exl;

    assign interrupt = (|int_pending) & int_enable;

endmodule

//--- verilog/cp0_regs.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0_regs (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  cp0_write,
    input  logic                  eret,
    input  logic                  exception,
    input  logic                  in_delay_slot,
    input  logic                  is_bad_addr,
    input  cp0_word_pkg::cp0_idx  cp0_idx,
    input  cp0_word_pkg::cp0_word cp0_wdata,
    input  cp0_word_pkg::cp0_word exc_pc,
    input  cp0_word_pkg::cp0_word bad_addr,
    input  logic [5:0]            exc_code_in,
    input  cp0_word_pkg::cp0_word count,
    input  cp0_word_pkg::cp0_word compare,
    input  cp0_exc_pkg::int_mask  int_pending,
    output cp0_exc_pkg::int_mask  status_im,
    output logic                  status_ie,
    output logic                  status_exl,
    output cp0_exc_pkg::sw_int    cause_sw,
    output cp0_word_pkg::cp0_word epc,
    output cp0_word_pkg::cp0_word cp0_rdata
);

    cp0_word_pkg::cp0_word badvaddr;
    logic                  cause_bd;
    cp0_exc_pkg::int_mask  cause_ip;
    cp0_exc_pkg::exc_code  cause_exc;

    cp0_word_pkg::cp0_word status_val;
    cp0_word_pkg::cp0_word cause_val;

    // eret first, then exception, then mtc0
    always_ff @(posedge clk) begin
        if (!resetn) begin
            status_im <= '0;
            status_exl <= 1'b0;
            status_ie <= `CP0_STATUS_RESET_IE;
            cause_bd <= 1'b0;
            cause_exc <= '0;
            cause_sw <= '0;
            epc <= '0;
            badvaddr <= '0;
        end else if (eret) begin
            status_exl <= 1'b0;
        end else if (exception) begin
            if (is_bad_addr) begin
                badvaddr <= bad_addr;
            end
            cause_exc <= exc_code_in[4:0];
            // nested trap keeps the first return address
            if (!status_exl) begin
                if (in_delay_slot) begin
                    epc <= exc_pc - `CP0_DSLOT_OFFSET;
                    cause_bd <= 1'b1;
                end else begin
                    epc <= exc_pc;
                    cause_bd <= 1'b0;
                end
                status_exl <= 1'b1;
            end
        end else if (cp0_write) begin
            case (cp0_idx)
                `CP0_STATUS: begin
                    status_im <= cp0_wdata[15:8];
                    status_exl <= cp0_wdata[1];
                    status_ie <= cp0_wdata[0];
                end
                `CP0_CAUSE: begin
                    cause_sw <= cp0_wdata[9:8];
                end
                `CP0_EPC: begin
                    epc <= cp0_wdata;
                end
                default: begin
                end
            endcase
        end
    end

    // IP follows the combiner one cycle late
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cause_ip <= '0;
        end else begin
            cause_ip <= int_pending;
        end
    end

    assign status_val = `CP0_STATUS_BEV | {16'h0000, status_im, 6'b00_0000, status_exl, status_ie};
    assign cause_val = {cause_bd, 15'h0000, cause_ip, 1'b0, cause_exc, 2'b00};

    always_comb begin
        case (cp0_idx)
            `CP0_BADVADDR: cp0_rdata = badvaddr;
            `CP0_COUNT:    cp0_rdata = count;
            `CP0_COMPARE:  cp0_rdata = compare;
            `CP0_STATUS:   cp0_rdata = status_val;
            `CP0_CAUSE:    cp0_rdata = cause_val;
            `CP0_EPC:      cp0_rdata = epc;
            default:       cp0_rdata = '0;
        endcase
    end

    // pipeline retires at most one of these per cycle
    a_eret_exc_exclusive: assert property (
        @(posedge clk) disable iff (!resetn)
        !(eret && exception)
    ) else $error("eret and exception asserted together");

    a_exc_sets_exl: assert property (
        @(posedge clk) disable iff (!resetn)
        exception |=> status_exl
    ) else $error("EXL not set after exception");

endmodule

//--- verilog/cp0_top.sv
`timescale 1ns/1ps

module cp0_top (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     cp0_write,
    input  cp0_word_pkg::cp0_idx     cp0_idx,
    input  cp0_word_pkg::cp0_word    cp0_wdata,
    input  logic                     exception,
    input  cp0_word_pkg::cp0_word    exc_pc,
    input  logic [5:0]               exc_code_in,
    input  logic                     in_delay_slot,
    input  logic                     is_bad_addr,
    input  cp0_word_pkg::cp0_word    bad_addr,
    input  logic                     eret,
    input  cp0_word_pkg::ext_int_vec ext_int,
    output cp0_word_pkg::cp0_word    cp0_rdata,
    output cp0_word_pkg::cp0_word    epc,
    output logic                     interrupt
);

    cp0_word_pkg::cp0_word count;
    cp0_word_pkg::cp0_word compare;
    logic                  timer_pending;
    cp0_exc_pkg::int_mask  status_im;
    logic                  status_ie;
    logic                  status_exl;
    cp0_exc_pkg::sw_int    cause_sw;
    cp0_exc_pkg::int_mask  int_pending;

    cp0_timer cp0_timer_inst (
        .clk           (clk),
        .resetn        (resetn),
        .cp0_write     (cp0_write),
        .eret          (eret),
        .exception     (exception),
        .cp0_idx       (cp0_idx),
        .cp0_wdata     (cp0_wdata),
        .count         (count),
        .compare       (compare),
        .timer_pending (timer_pending)
    );

    cp0_irq cp0_irq_inst (
        .ext_int       (ext_int),
        .timer_pending (timer_pending),
        .cause_sw      (cause_sw),
        .status_im     (status_im),
        .status_ie     (status_ie),
        .status_exl    (status_exl),
        .int_pending   (int_pending),
        .interrupt     (interrupt)
    );

    cp0_regs cp0_regs_inst (
        .clk           (clk),
        .resetn        (resetn),
        .cp0_write     (cp0_write),
        .eret          (eret),
        .exception     (exception),
        .in_delay_slot (in_delay_slot),
        .is_bad_addr   (is_bad_addr),
        .cp0_idx       (cp0_idx),
        .cp0_wdata     (cp0_wdata),
        .exc_pc        (exc_pc),
        .bad_addr      (bad_addr),
        .exc_code_in   (exc_code_in),
        .count         (count),
        .compare       (compare),
        .int_pending   (int_pending),
        .status_im     (status_im),
        .status_ie     (status_ie),
        .status_exl    (status_exl),
        .cause_sw      (cause_sw),
        .epc           (epc),
        .cp0_rdata     (cp0_rdata)
    );

endmodule

//--- bench/cp0_tb.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0_tb;

    localparam logic [2:0] OP_READ = 3'd0;
    localparam logic [2:0] OP_WRITE = 3'd1;
    localparam logic [2:0] OP_EXC = 3'd2;
    localparam logic [2:0] OP_EXC_WR = 3'd3;
    localparam logic [2:0] OP_ERET = 3'd4;
    localparam logic [2:0] OP_EXT = 3'd5;

    typedef struct packed {
        logic [2:0]  op;
        logic [4:0]  idx;
        logic [31:0] data;
        logic [31:0] pc;
        logic [5:0]  code;
        logic        dslot;
        logic        bad;
        logic [31:0] baddr;
        logic [31:0] exp_rdata;
        logic        chk_rdata;
        logic        exp_int;
    } row_t;

    logic        clk = 1'b0;
    logic        resetn;
    logic        cp0_write;
    logic [4:0]  cp0_idx;
    logic [31:0] cp0_wdata;
    logic        exception;
    logic [31:0] exc_pc;
    logic [5:0]  exc_code_in;
    logic        in_delay_slot;
    logic        is_bad_addr;
    logic [31:0] bad_addr;
    logic        eret;
    logic [5:0]  ext_int;
    logic [31:0] cp0_rdata;
    logic [31:0] epc;
    logic        interrupt;

    row_t rows[$];
    int   error_count = 0;
    int   tests_run = 0;
    int   tests_failed = 0;

    always #5 clk = ~clk;

    cp0_top cp0_top_inst (
        .clk           (clk),
        .resetn        (resetn),
        .cp0_write     (cp0_write),
        .cp0_idx       (cp0_idx),
        .cp0_wdata     (cp0_wdata),
        .exception     (exception),
        .exc_pc        (exc_pc),
        .exc_code_in   (exc_code_in),
        .in_delay_slot (in_delay_slot),
        .is_bad_addr   (is_bad_addr),
        .bad_addr      (bad_addr),
        .eret          (eret),
        .ext_int       (ext_int),
        .cp0_rdata     (cp0_rdata),
        .epc           (epc),
        .interrupt     (interrupt)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic table_row(input logic [2:0] op, input logic [4:0] idx,
                             input logic [31:0] data, input logic [31:0] exp_rdata,
                             input logic chk_rdata, input logic exp_int);
        row_t r;
        r = '0;
        r.op = op;
        r.idx = idx;
        r.data = data;
        r.exp_rdata = exp_rdata;
        r.chk_rdata = chk_rdata;
        r.exp_int = exp_int;
        rows.push_back(r);
    endtask

    task automatic trap_row(input logic [2:0] op, input logic [4:0] idx,
                            input logic [31:0] data, input logic [31:0] pc,
                            input logic [5:0] code, input logic dslot, input logic bad,
                            input logic [31:0] baddr, input logic [31:0] exp_rdata,
                            input logic exp_int);
        row_t r;
        r = '0;
        r.op = op;
        r.idx = idx;
        r.data = data;
        r.pc = pc;
        r.code = code;
        r.dslot = dslot;
        r.bad = bad;
        r.baddr = baddr;
        r.exp_rdata = exp_rdata;
        r.chk_rdata = 1'b1;
        r.exp_int = exp_int;
        rows.push_back(r);
    endtask

    // one request cycle, one cycle for the write to land, one more for Cause.IP
    task automatic apply_row(input row_t r);
        @(posedge clk);
        cp0_idx <= r.idx;
        if (r.op == OP_WRITE || r.op == OP_EXC_WR) begin
            cp0_write <= 1'b1;
            cp0_wdata <= r.data;
        end
        if (r.op == OP_EXC || r.op == OP_EXC_WR) begin
            exception <= 1'b1;
            exc_pc <= r.pc;
            exc_code_in <= r.code;
            in_delay_slot <= r.dslot;
            is_bad_addr <= r.bad;
            bad_addr <= r.baddr;
        end
        if (r.op == OP_ERET) begin
            eret <= 1'b1;
        end
        if (r.op == OP_EXT) begin
            ext_int <= r.data[5:0];
        end
        @(posedge clk);
        cp0_write <= 1'b0;
        exception <= 1'b0;
        eret <= 1'b0;
        in_delay_slot <= 1'b0;
        is_bad_addr <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (r.chk_rdata) begin
            check_value("cp0_rdata", cp0_rdata, r.exp_rdata);
            // epc port always carries the EPC register
            if (r.idx == `CP0_EPC) begin
                check_value("epc", epc, r.exp_rdata);
            end
        end
        check_value("interrupt", {31'd0, interrupt}, {31'd0, r.exp_int});
    endtask

    task automatic run_table();
        while (rows.size() > 0) begin
            apply_row(rows.pop_front());
        end
    endtask

    task automatic close_test(input string name, input int errs_at_start);
        tests_run++;
        if (error_count != errs_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errs_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] p;
        logic [31:0] q;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] c0;
        logic [31:0] c1;
        logic [7:0]  m;
        logic [1:0]  sw;
        int          errs;
        int          waited;

        void'($urandom(51));
        resetn <= 1'b0;
        cp0_write <= 1'b0;
        cp0_idx <= '0;
        cp0_wdata <= '0;
        exception <= 1'b0;
        exc_pc <= '0;
        exc_code_in <= '0;
        in_delay_slot <= 1'b0;
        is_bad_addr <= 1'b0;
        bad_addr <= '0;
        eret <= 1'b0;
        ext_int <= '0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        // Count runs freely after reset and is left to the timer test
        errs = error_count;
        table_row(OP_READ, `CP0_STATUS, 0, 32'h0040_0001, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_CAUSE, 0, 32'h0, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_EPC, 0, 32'h0, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_BADVADDR, 0, 32'h0, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_COMPARE, 0, 32'h0, 1'b1, 1'b0);
        run_table();
        close_test("reset", errs);

        errs = error_count;
        r0 = $urandom();
        r1 = $urandom();
        r2 = $urandom();
        table_row(OP_WRITE, `CP0_EPC, r0, r0, 1'b1, 1'b0);
        table_row(OP_WRITE, `CP0_STATUS, r1, `CP0_STATUS_BEV | (r1 & 32'h0000_ff03), 1'b1, 1'b0);
        table_row(OP_WRITE, `CP0_STATUS, 32'h0000_0300, 32'h0040_0300, 1'b1, 1'b0);
        table_row(OP_WRITE, `CP0_CAUSE, r2, r2 & 32'h0000_0300, 1'b1, 1'b0);
        table_row(OP_WRITE, `CP0_BADVADDR, $urandom(), 32'h0, 1'b1, 1'b0);
        table_row(OP_WRITE, `CP0_CAUSE, 32'h0, 32'h0, 1'b1, 1'b0);
        run_table();
        close_test("mtc0", errs);

        errs = error_count;
        p = $urandom() & 32'hffff_fffc;
        q = ($urandom() & 32'h0fff_fffc) | 32'h0000_0100;
        b = $urandom();
        // top bit of the code is dropped so 0x24 lands as 0x04
        trap_row(OP_EXC, `CP0_EPC, 0, p, 6'h24, 1'b0, 1'b1, b, p, 1'b0);
        table_row(OP_READ, `CP0_CAUSE, 0, 32'h0000_0010, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_BADVADDR, 0, b, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_STATUS, 0, 32'h0040_0302, 1'b1, 1'b0);
        trap_row(OP_EXC, `CP0_CAUSE, 0, q, 6'h05, 1'b1, 1'b0, 0, 32'h0000_0014, 1'b0);
        table_row(OP_READ, `CP0_EPC, 0, p, 1'b1, 1'b0);
        table_row(OP_ERET, `CP0_STATUS, 0, 32'h0040_0300, 1'b1, 1'b0);
        trap_row(OP_EXC, `CP0_EPC, 0, q, 6'h0c, 1'b1, 1'b0, 0, q - 32'd4, 1'b0);
        table_row(OP_READ, `CP0_CAUSE, 0, 32'h8000_0030, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_BADVADDR, 0, b, 1'b1, 1'b0);
        // write in the same cycle as a trap is lost
        trap_row(OP_EXC_WR, `CP0_EPC, $urandom(), p, 6'h0d, 1'b0, 1'b0, 0, q - 32'd4, 1'b0);
        table_row(OP_READ, `CP0_CAUSE, 0, 32'h8000_0034, 1'b1, 1'b0);
        table_row(OP_ERET, `CP0_STATUS, 0, 32'h0040_0300, 1'b1, 1'b0);
        run_table();
        close_test("exception", errs);

        errs = error_count;
        table_row(OP_WRITE, `CP0_STATUS, 32'h0000_0403, 32'h0040_0403, 1'b1, 1'b0);
        table_row(OP_EXT, `CP0_STATUS, 32'h1, 32'h0040_0403, 1'b1, 1'b0);
        table_row(OP_ERET, `CP0_STATUS, 0, 32'h0040_0401, 1'b1, 1'b1);
        table_row(OP_READ, `CP0_CAUSE, 0, 32'h8000_0434, 1'b1, 1'b1);
        table_row(OP_EXT, `CP0_STATUS, 32'h0, 32'h0040_0401, 1'b1, 1'b0);
        run_table();
        close_test("eret", errs);

        errs = error_count;
        for (int i = 0; i < 6; i++) begin
            m = 8'd1 << (i + 2);
            table_row(OP_WRITE, `CP0_STATUS, {16'h0, m, 8'h01},
                      `CP0_STATUS_BEV | {16'h0, m, 8'h01}, 1'b1, 1'b0);
            table_row(OP_EXT, `CP0_STATUS, 32'h1 << i,
                      `CP0_STATUS_BEV | {16'h0, m, 8'h01}, 1'b1, 1'b1);
            m = ~m;
            table_row(OP_WRITE, `CP0_STATUS, {16'h0, m, 8'h01},
                      `CP0_STATUS_BEV | {16'h0, m, 8'h01}, 1'b1, 1'b0);
            table_row(OP_EXT, `CP0_STATUS, 32'h0,
                      `CP0_STATUS_BEV | {16'h0, m, 8'h01}, 1'b1, 1'b0);
        end
        for (int j = 0; j < 2; j++) begin
            sw = 2'd1 << j;
            m = {6'd0, sw};
            table_row(OP_WRITE, `CP0_STATUS, {16'h0, m, 8'h01},
                      `CP0_STATUS_BEV | {16'h0, m, 8'h01}, 1'b1, 1'b0);
            table_row(OP_WRITE, `CP0_CAUSE, {22'd0, sw, 8'd0},
                      32'h8000_0034 | {22'd0, sw, 8'd0}, 1'b1, 1'b1);
            m = ~m;
            table_row(OP_WRITE, `CP0_STATUS, {16'h0, m, 8'h01},
                      `CP0_STATUS_BEV | {16'h0, m, 8'h01}, 1'b1, 1'b0);
            table_row(OP_WRITE, `CP0_CAUSE, 32'h0, 32'h8000_0034, 1'b1, 1'b0);
        end
        run_table();
        close_test("masking", errs);

        errs = error_count;
        c = $urandom() | 32'h1000_0000;
        table_row(OP_WRITE, `CP0_STATUS, 32'h0000_8001, 32'h0040_8001, 1'b1, 1'b0);
        table_row(OP_WRITE, `CP0_COMPARE, c, c, 1'b1, 1'b0);
        table_row(OP_WRITE, `CP0_COUNT, c - 32'd8, 0, 1'b0, 1'b0);
        run_table();
        // one tick at most since the Count write landed
        check_value("count_near_write", {31'd0, (cp0_rdata - (c - 32'd8)) <= 32'd1}, 32'd1);
        @(posedge clk);
        cp0_idx <= `CP0_CAUSE;
        @(negedge clk);
        waited = 0;
        while (!interrupt && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (!interrupt) begin
            $display("timer interrupt did not rise within 64 cycles at t=%0t", $time);
            error_count++;
        end
        @(posedge clk);
        @(negedge clk);
        check_value("cause_timer", cp0_rdata, 32'h8000_8034);
        table_row(OP_WRITE, `CP0_COMPARE, c - 32'd100, c - 32'd100, 1'b1, 1'b0);
        table_row(OP_READ, `CP0_CAUSE, 0, 32'h8000_0034, 1'b1, 1'b0);
        run_table();
        @(posedge clk);
        cp0_idx <= `CP0_COUNT;
        @(negedge clk);
        c0 = cp0_rdata;
        repeat (20) @(negedge clk);
        c1 = cp0_rdata;
        check_value("count_step", c1 - c0, 32'd10);
        close_test("timer", errs);

        $display("tests: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
verilog/cp0_word_pkg.sv
verilog/cp0_exc_pkg.sv
verilog/cp0_timer.sv
verilog/cp0_irq.sv
verilog/cp0_regs.sv
verilog/cp0_top.sv
bench/cp0_tb.sv

//--- Makefile
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module cp0_tb \
		-Mdir obj_dir -f filelist.f
	./obj_dir/Vcp0_tb | tee sim.log
	grep -F -q "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
